// File: tb.f
uart_pkg.sv
uart_tx.sv
uart_rx.sv
uart_wb_regs.sv
uart_top.sv
tb_clock_gen.sv
uart_checker.sv
uart_assertions.sv
uart_tb.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module uart_tb -f tb.f -o uart_sim \
	&& ./obj_dir/uart_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "RESULT: build or simulation aborted"; exit 1; }
cat sim.log
if grep -q "Some tests failed" sim.log; then
	echo "RESULT: FAIL"
	exit 1
fi
echo "RESULT: PASS"
exit 0

// File: uart_tb.sv
`timescale 1ns/1ps

module uart_tb;

	localparam int NUM_ROWS      = 7;
	localparam int MAX_CYC       = NUM_ROWS * 11 * 16 * 3 + 200;	// three frames of slack per row
	localparam logic [1:0] M_LOOP   = 2'd0;	// byte goes out o_tx and back in i_rx
	localparam logic [1:0] M_DOUBLE = 2'd1;	// loopback with a second write while busy
	localparam logic [1:0] M_DIRECT = 2'd2;	// testbench drives i_rx
	localparam logic [1:0] C_NONE   = 2'd0;
	localparam logic [1:0] C_PARITY = 2'd1;
	localparam logic [1:0] C_STOP   = 2'd2;

	typedef struct packed {
		logic [1:0] mode;
		logic       rnd;	// byte comes from $urandom
		logic [7:0] data;
		logic [1:0] corrupt;
		logic       exp_err;
	} row_t;

	logic              clk;
	logic              reset;
	uart_pkg::wb_req_t wb_req;
	uart_pkg::wb_rsp_t wb_rsp;
	logic              tx_line;
	logic              rx_line;
	logic              drv_rx;
	logic              loop_en;
	logic              chk_en;
	logic [1:0]        chk_id;
	logic [7:0]        chk_exp;
	int                errors;
	int                checks;
	int                cycles = 0;
	row_t              rows [NUM_ROWS];

	assign rx_line = loop_en ? tx_line : drv_rx;

	tb_clock_gen #(.PERIOD_NS(100)) u_clk (.o_clk(clk));

	uart_top #(
		.CLKS_PER_BIT (16),
		.PARITY_EN    (1),
		.PARITY_ODD   (0)
	) DUT (
		.clk   (clk),
		.reset (reset),
		.i_wb  (wb_req),
		.o_wb  (wb_rsp),
		.o_tx  (tx_line),
		.i_rx  (rx_line)
	);

	uart_checker u_checker (
		.clk      (clk),
		.reset    (reset),
		.i_wb     (wb_req),
		.i_rsp    (wb_rsp),
		.i_tx     (tx_line),
		.i_chk_en (chk_en),
		.i_chk_id (chk_id),
		.i_exp    (chk_exp),
		.o_errors (errors),
		.o_checks (checks)
	);

	bind uart_top uart_assertions u_assertions (
		.clk   (clk),
		.reset (reset),
		.i_wb  (i_wb),
		.i_rsp (o_wb),
		.i_tx  (o_tx)
	);

	// one classic access with stb dropped in the cycle after ack
	task automatic bus_access(input logic we, input logic [1:0] adr, input logic [7:0] wdat,
			input logic check, input logic [7:0] exp, output logic [7:0] rdat);
		@(posedge clk);
		#1;
		chk_en  = check;
		chk_id  = adr;
		chk_exp = exp;
		wb_req  = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		do begin
			@(posedge clk);
			#1;
		end while (!wb_rsp.ack);
		rdat = wb_rsp.dat;
		@(posedge clk);	// slave still sees stb while ack is high
		#1;
		wb_req = '0;
	endtask

	task automatic wait_status(input int bit_pos, input logic level);
		logic [7:0] st;
		do begin
			bus_access(1'b0, uart_pkg::STATUS, 8'h00, 1'b0, 8'h00, st);
		end while (st[bit_pos] !== level);
	endtask

	// start, 8 data bits lsb first, even parity, stop; 16 clocks each
	task automatic send_frame(input logic [7:0] data, input logic [1:0] corrupt);
		logic [10:0] bits;
		bits = {corrupt != C_STOP, (^data) ^ (corrupt == C_PARITY), data, 1'b0};
		@(posedge clk);
		#1;
		for (int i = 0; i < 11; i++) begin
			drv_rx = bits[i];
			repeat (16) @(posedge clk);
			#1;
		end
		drv_rx = 1'b1;
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYC) begin
			$display("Timeout: no result after %0d cycles", MAX_CYC);
			$display("Some tests failed");
			$finish;
		end
	end

	initial begin
		logic [7:0] rd;
		logic [7:0] data;
		logic       prev_err;
		row_t       r;
		void'($urandom(82));
		reset   = 1'b1;
		wb_req  = '0;
		drv_rx  = 1'b1;
		loop_en = 1'b1;
		chk_en  = 1'b0;
		chk_id  = 2'd0;
		chk_exp = 8'h00;
		rows[0] = '{M_LOOP, 1'b0, 8'hA5, C_NONE, 1'b0};
		rows[1] = '{M_LOOP, 1'b1, 8'h00, C_NONE, 1'b0};
		rows[2] = '{M_DOUBLE, 1'b0, 8'h3C, C_NONE, 1'b0};
		rows[3] = '{M_DIRECT, 1'b0, 8'h5A, C_PARITY, 1'b1};
		rows[4] = '{M_DIRECT, 1'b1, 8'h00, C_STOP, 1'b1};
		rows[5] = '{M_DIRECT, 1'b0, 8'h81, C_NONE, 1'b0};
		rows[6] = '{M_LOOP, 1'b1, 8'h00, C_NONE, 1'b0};
		repeat (8) @(posedge clk);
		#1;
		reset    = 1'b0;
		prev_err = 1'b0;
		bus_access(1'b0, uart_pkg::STATUS, 8'h00, 1'b1, 8'h00, rd);	// all flags clear
		foreach (rows[i]) begin
			r       = rows[i];
			data    = r.rnd ? 8'($urandom) : r.data;
			loop_en = (r.mode != M_DIRECT);
			if (r.mode == M_DIRECT) begin
				send_frame(data, r.corrupt);
			end else begin
				bus_access(1'b1, uart_pkg::TXDATA, data, 1'b0, 8'h00, rd);
				if (r.mode == M_DOUBLE) begin
					bus_access(1'b1, uart_pkg::TXDATA, ~data, 1'b0, 8'h00, rd);	// lands while busy
				end
				bus_access(1'b0, uart_pkg::STATUS, 8'h00, 1'b1, {5'b0, 2'b10, prev_err}, rd);
			end
			wait_status(1, 1'b1);	// rx_valid
			bus_access(1'b0, uart_pkg::RXDATA, 8'h00, 1'b1, data, rd);
			if (r.mode != M_DIRECT) begin
				wait_status(2, 1'b0);	// stop bit finished
			end
			bus_access(1'b0, uart_pkg::STATUS, 8'h00, 1'b1, {7'b0, r.exp_err}, rd);
			prev_err = r.exp_err;
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: uart_assertions.sv
`timescale 1ns/1ps

module uart_assertions (
	input logic              clk,
	input logic              reset,
	input uart_pkg::wb_req_t i_wb,
	input uart_pkg::wb_rsp_t i_rsp,
	input logic              i_tx
);

	// ack lasts one cycle only
	ack_single: assert property (@(posedge clk) disable iff (reset) i_rsp.ack |=> !i_rsp.ack)
		else $error("ack high in two consecutive cycles");

	ack_after_req: assert property (@(posedge clk) disable iff (reset)
		i_rsp.ack |-> $past(i_wb.cyc && i_wb.stb))
		else $error("ack without cyc and stb in the previous cycle");

	tx_idle_reset: assert property (@(posedge clk) reset |=> i_tx)	// also the cycle after
		else $error("serial line not high during or after reset");

endmodule

// File: uart_checker.sv
`timescale 1ns/1ps

module uart_checker (
	input  logic                        clk,
	input  logic                        reset,
	input  uart_pkg::wb_req_t           i_wb,
	input  uart_pkg::wb_rsp_t           i_rsp,
	input  logic                        i_tx,
	input  logic                        i_chk_en,	// compare read data of the current access
	input  logic [1:0]                  i_chk_id,	// register address of that access
	input  logic [uart_pkg::DATA_W-1:0] i_exp,
	output int                          o_errors,
	output int                          o_checks
);

	localparam int W = uart_pkg::DATA_W;

	int   errors = 0;
	int   checks = 0;
	logic req_q;	// cyc and stb at the last edge
	logic new_q;	// request started at the last edge
	logic reset_q;

	assign o_errors = errors;
	assign o_checks = checks;

	task automatic compare(input string name, input logic [W-1:0] exp, input logic [W-1:0] got);
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	// flags compared one by one so a wrong bit is named
	task automatic compare_status(input logic [W-1:0] exp, input logic [W-1:0] got);
		uart_pkg::uart_status_t st_exp;
		uart_pkg::uart_status_t st_got;
		st_exp = uart_pkg::uart_status_t'(exp[2:0]);
		st_got = uart_pkg::uart_status_t'(got[2:0]);
		compare("STATUS.tx_busy", W'(st_exp.tx_busy), W'(st_got.tx_busy));
		compare("STATUS.rx_valid", W'(st_exp.rx_valid), W'(st_got.rx_valid));
		compare("STATUS.rx_error", W'(st_exp.rx_error), W'(st_got.rx_error));
		compare("STATUS[7:3]", W'(exp[W-1:3]), W'(got[W-1:3]));	// always zero
	endtask

	always @(posedge clk) begin
		if (reset) begin
			req_q   <= 1'b0;
			new_q   <= 1'b0;
			reset_q <= 1'b1;
		end else begin
			req_q   <= i_wb.cyc && i_wb.stb;
			new_q   <= i_wb.cyc && i_wb.stb && !req_q;
			reset_q <= 1'b0;
			if (reset_q) begin
				compare("o_tx", W'(1), W'(i_tx));	// idle high right out of reset
			end
			if (new_q && !i_rsp.ack) begin	// fixed one-cycle latency
				errors++;
				$display("Error at %0t: no ack one cycle after stb", $time);
			end
			if (i_rsp.ack && i_chk_en) begin
				checks++;
				if (i_chk_id == uart_pkg::STATUS) begin
					compare_status(i_exp, i_rsp.dat);
				end else begin
					compare("RXDATA", i_exp, i_rsp.dat);
				end
			end
		end
	end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 100
) (
	output logic o_clk
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2) o_clk = ~o_clk;	// 50 ns high, 50 ns low
	end

endmodule

// File: uart_top.sv
`timescale 1ns/1ps

module uart_top #(
	parameter int CLKS_PER_BIT = 16,
	parameter int PARITY_EN    = 1,
	parameter int PARITY_ODD   = 0	// 0 even, 1 odd
) (
	input  logic              clk,
	input  logic              reset,
	input  uart_pkg::wb_req_t i_wb,
	output uart_pkg::wb_rsp_t o_wb,
	output logic              o_tx,	// serial out
	input  logic              i_rx	// serial in
);

	logic                        tx_start;
	logic [uart_pkg::DATA_W-1:0] tx_data;
	logic                        tx_busy;
	logic                        rx_done;
	uart_pkg::rx_frame_t         rx_frame;

	uart_wb_regs u_regs (
		.clk        (clk),
		.reset      (reset),
		.i_wb       (i_wb),
		.o_wb       (o_wb),
		.o_tx_start (tx_start),
		.o_tx_data  (tx_data),
		.i_tx_busy  (tx_busy),
		.i_rx_done  (rx_done),
		.i_rx_frame (rx_frame)
	);

	uart_tx #(
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.PARITY_EN    (PARITY_EN),
		.PARITY_ODD   (PARITY_ODD)
	) u_tx (
		.clk     (clk),
		.reset   (reset),
		.i_start (tx_start),
		.i_data  (tx_data),
		.o_busy  (tx_busy),
		.o_tx    (o_tx)
	);

	uart_rx #(
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.PARITY_EN    (PARITY_EN),
		.PARITY_ODD   (PARITY_ODD)
	) u_rx (
		.clk     (clk),
		.reset   (reset),
		.i_rx    (i_rx),
		.o_done  (rx_done),
		.o_frame (rx_frame)
	);

endmodule

// File: uart_wb_regs.sv
`timescale 1ns/1ps

module uart_wb_regs (
	input  logic                        clk,
	input  logic                        reset,
	input  uart_pkg::wb_req_t           i_wb,
	output uart_pkg::wb_rsp_t           o_wb,
	output logic                        o_tx_start,	// one cycle, together with ack
	output logic [uart_pkg::DATA_W-1:0] o_tx_data,
	input  logic                        i_tx_busy,
	input  logic                        i_rx_done,
	input  uart_pkg::rx_frame_t         i_rx_frame
);

	uart_pkg::uart_reg_addr_e    addr;
	uart_pkg::uart_status_t      status;
	logic                        bus_req;	// new access, not yet acked
	logic                        ack_q;
	logic [uart_pkg::DATA_W-1:0] rd_data;
	logic [uart_pkg::DATA_W-1:0] tx_data_q;
	logic [uart_pkg::DATA_W-1:0] rx_data_q;
	logic                        rx_valid;
	logic                        rx_error;

	assign addr    = uart_pkg::uart_reg_addr_e'(i_wb.adr);
	assign bus_req = i_wb.cyc && i_wb.stb && !ack_q;	// stb still high in ack cycle
	assign status  = '{tx_busy: i_tx_busy, rx_valid: rx_valid, rx_error: rx_error};

	assign o_wb      = '{ack: ack_q, dat: rd_data};
	assign o_tx_data = tx_data_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			ack_q      <= 1'b0;
			o_tx_start <= 1'b0;
			rd_data    <= '0;
		end else begin
			ack_q      <= bus_req;	// fixed one-cycle latency
			o_tx_start <= 1'b0;
			if (bus_req && i_wb.we) begin
				if (addr == uart_pkg::TXDATA && !i_tx_busy) begin	// busy write acked and dropped
					o_tx_start <= 1'b1;
					tx_data_q  <= i_wb.dat;
				end
			end else if (bus_req) begin
				case (addr)
					uart_pkg::TXDATA: rd_data <= tx_data_q;	// last byte sent
					uart_pkg::RXDATA: rd_data <= rx_data_q;
					uart_pkg::STATUS: rd_data <= uart_pkg::DATA_W'(status);	// zeros above
					default:          rd_data <= '0;
				endcase
			end
		end
	end

	// receive holding register, newest frame wins
	always_ff @(posedge clk) begin
		if (reset) begin
			rx_valid <= 1'b0;
			rx_error <= 1'b0;
		end else begin
			if (bus_req && !i_wb.we && addr == uart_pkg::RXDATA) begin
				rx_valid <= 1'b0;	// low from the ack cycle on
			end
			if (i_rx_done) begin	// a frame landing with the read still sets it
				rx_valid  <= 1'b1;
				rx_error  <= i_rx_frame.error;
				rx_data_q <= i_rx_frame.data;
			end
		end
	end

endmodule

// File: uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
	parameter int CLKS_PER_BIT = 16,
	parameter int PARITY_EN    = 1,
	parameter int PARITY_ODD   = 0
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                i_rx,	// asynchronous serial line
	output logic                o_done,	// one-cycle pulse at stop bit center
	output uart_pkg::rx_frame_t o_frame
);

	localparam int FRAME_BITS = uart_pkg::DATA_W + PARITY_EN + 2;
	localparam int CNT_W      = $clog2(CLKS_PER_BIT);
	localparam int BIT_W      = $clog2(FRAME_BITS);

	uart_pkg::rx_state_e         state;
	logic [2:0]                  sync;	// three-flop synchronizer
	logic                        rx_s;	// synchronized line
	logic                        rx_d;	// rx_s one clock later, for edge detect
	logic [CNT_W-1:0]            clk_cnt;
	logic [BIT_W-1:0]            bit_idx;	// frame position of next sample
	logic [uart_pkg::DATA_W-1:0] data_sr;	// filled from the top, lsb arrives first
	logic                        par_err;
	logic                        half_bit;
	logic                        full_bit;

	assign rx_s     = sync[2];
	assign half_bit = (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1));
	assign full_bit = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			sync <= 3'b111;	// idle high, no false start out of reset
			rx_d <= 1'b1;
		end else begin
			sync <= {sync[1:0], i_rx};
			rx_d <= rx_s;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= uart_pkg::RX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			par_err <= 1'b0;
			o_done  <= 1'b0;
		end else begin
			o_done <= 1'b0;
			case (state)
				uart_pkg::RX_IDLE: begin
					clk_cnt <= '0;
					if (rx_d && !rx_s) begin	// falling edge, a stuck-low line never restarts
						state   <= uart_pkg::RX_START;
						par_err <= 1'b0;
					end
				end
				uart_pkg::RX_START: begin
					if (half_bit) begin
						clk_cnt <= '0;
						bit_idx <= BIT_W'(1);
						// still low at the center, else it was a glitch
						state   <= rx_s ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
					end else begin
						clk_cnt <= clk_cnt + CNT_W'(1);
					end
				end
				default: begin	// data, parity and stop share one bit timer
					if (!full_bit) begin
						clk_cnt <= clk_cnt + CNT_W'(1);
					end else begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + BIT_W'(1);
						if (bit_idx == BIT_W'(FRAME_BITS - 1)) begin	// stop bit center
							state         <= uart_pkg::RX_IDLE;
							o_done        <= 1'b1;
							o_frame.data  <= data_sr;
							o_frame.error <= par_err | !rx_s;	// low stop is a framing error
						end else if (state == uart_pkg::RX_DATA) begin
							data_sr <= {rx_s, data_sr[uart_pkg::DATA_W-1:1]};
							if (bit_idx == BIT_W'(uart_pkg::DATA_W)) begin
								state <= (PARITY_EN != 0) ? uart_pkg::RX_PARITY
								                          : uart_pkg::RX_STOP;
							end
						end else begin	// parity bit center
							par_err <= rx_s ^ (^data_sr) ^ (PARITY_ODD != 0);
							state   <= uart_pkg::RX_STOP;
						end
					end
				end
			endcase
		end
	end

endmodule

// File: uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
	parameter int CLKS_PER_BIT = 16,
	parameter int PARITY_EN    = 1,
	parameter int PARITY_ODD   = 0
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        i_start,	// one-cycle pulse
	input  logic [uart_pkg::DATA_W-1:0] i_data,
	output logic                        o_busy,
	output logic                        o_tx
);

	localparam int FRAME_BITS = uart_pkg::DATA_W + PARITY_EN + 2;	// start, data, parity, stop
	localparam int CNT_W      = $clog2(CLKS_PER_BIT);
	localparam int BIT_W      = $clog2(FRAME_BITS);

	uart_pkg::tx_state_e         state;
	logic [CNT_W-1:0]            clk_cnt;	// clocks into current bit
	logic [BIT_W-1:0]            bit_idx;	// position in frame, start bit is 0
	logic [uart_pkg::DATA_W-1:0] data_sr;	// shifts right, lsb goes out first
	logic                        par_bit;
	logic                        bit_end;

	assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
	assign o_busy  = (state != uart_pkg::TX_IDLE);	// high through last stop clock

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= uart_pkg::TX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			o_tx    <= 1'b1;	// line idles high
		end else if (i_start) begin	// register block only pulses when idle
			state   <= uart_pkg::TX_START;
			clk_cnt <= '0;
			bit_idx <= '0;
			o_tx    <= 1'b0;	// start bit
			data_sr <= i_data;
			par_bit <= (^i_data) ^ (PARITY_ODD != 0);	// inverted for odd
		end else if (state != uart_pkg::TX_IDLE) begin
			if (!bit_end) begin
				clk_cnt <= clk_cnt + CNT_W'(1);
			end else begin
				clk_cnt <= '0;
				bit_idx <= bit_idx + BIT_W'(1);
				if (bit_idx == BIT_W'(FRAME_BITS - 1)) begin	// stop bit done
					state <= uart_pkg::TX_IDLE;
					o_tx  <= 1'b1;
				end else begin
					case (state)
						uart_pkg::TX_START: begin
							state   <= uart_pkg::TX_DATA;
							o_tx    <= data_sr[0];
							data_sr <= data_sr >> 1;
						end
						uart_pkg::TX_DATA: begin
							if (bit_idx == BIT_W'(uart_pkg::DATA_W)) begin	// last data bit sent
								if (PARITY_EN != 0) begin
									state <= uart_pkg::TX_PARITY;
									o_tx  <= par_bit;
								end else begin
									state <= uart_pkg::TX_STOP;
									o_tx  <= 1'b1;
								end
							end else begin
								o_tx    <= data_sr[0];
								data_sr <= data_sr >> 1;
							end
						end
						uart_pkg::TX_PARITY: begin
							state <= uart_pkg::TX_STOP;
							o_tx  <= 1'b1;	// stop bit
						end
						default: begin
							state <= uart_pkg::TX_IDLE;	// not reached
							o_tx  <= 1'b1;
						end
					endcase
				end
			end
		end
	end

endmodule

// File: uart_pkg.sv
package uart_pkg;

	localparam int DATA_W = 8;	// one character, fixed by the register map

	// register addresses on the two-bit bus address
	typedef enum logic [1:0] {
		TXDATA = 2'd0,	// write starts a frame when idle
		RXDATA = 2'd1,	// read returns last frame and clears rx_valid
		STATUS = 2'd2	// busy and receive flags in the low bits
	} uart_reg_addr_e;

	typedef enum logic [2:0] {
		TX_IDLE   = 3'd0,
		TX_START  = 3'd1,
		TX_DATA   = 3'd2,
		TX_PARITY = 3'd3,
		TX_STOP   = 3'd4
	} tx_state_e;

	typedef enum logic [2:0] {
		RX_IDLE   = 3'd0,
		RX_START  = 3'd1,	// waiting for start bit center
		RX_DATA   = 3'd2,
		RX_PARITY = 3'd3,
		RX_STOP   = 3'd4
	} rx_state_e;

	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [1:0]        adr;
		logic [DATA_W-1:0] dat;	// write data
	} wb_req_t;

	typedef struct packed {
		logic              ack;	// one cycle per access
		logic [DATA_W-1:0] dat;	// read data, valid with ack
	} wb_rsp_t;

	typedef struct packed {
		logic tx_busy;	// bit 2
		logic rx_valid;	// bit 1
		logic rx_error;	// bit 0
	} uart_status_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic              error;	// parity or framing
	} rx_frame_t;

endpackage
